//--- exec_unit.f
logic/alu_pkg.sv
logic/step_counter.sv
logic/div_unit.sv
logic/alu_core.sv
logic/alu_seq.sv
logic/exec_unit.sv
sim/exec_unit_tb.sv

//--- logic/alu_core.sv
/*
 * Execution core
 * Captures the operation and its operands, steps the multi-shift working
 * word, computes results and condition codes with 6809 flag rules, and
 * holds the results. The capture cycle shows the new values directly.
 */
module alu_core import alu_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    cen,
    input  logic    op_load,
    input  logic    shift_step,
    input  logic    capture,
    input  alu_op_t op,
    input  word_t   opnd0,
    input  word_t   opnd1,
    input  cc_t     cc_in,
    input  word_t   quot,
    input  byte_t   rem,
    input  logic    div_v,
    output word_t   rslt,
    output word_t   rslt_hi,
    output cc_t     cc_out
);

alu_op_t     op_q;
word_t       a_q;
word_t       b_q;
cc_t         cc_q;
word_t       work_q;
logic        work_c;
logic        work_v;
logic [17:0] step_nxt;
word_t       res;
word_t       res_hi;
cc_t         cc_new;
logic [8:0]  sum9;
logic [16:0] sum17;
logic [31:0] prod;
logic        wide;
logic        keep_zn;
byte_t       a8;
byte_t       b8;
logic        cin;
word_t       rslt_q;
word_t       rslt_hi_q;
cc_t         cc_out_q;

// One bit of a multi-shift, returns {v, c, word}
function automatic logic [17:0] shift_one(alu_op_t sop, word_t w, logic c, logic v);
    word_t nw;
    logic  nc;
    logic  nv;
    nw = w;
    nc = c;
    nv = v;
    case (sop)
        OP_ASLD: begin
            nw = {w[14:0], 1'b0};
            nc = w[15];
            nv = w[15] ^ w[14];
        end
        OP_ASRD: begin
            nw = {w[15], w[15:1]};
            nc = w[0];
        end
        OP_LSRD: begin
            nw = {1'b0, w[15:1]};
            nc = w[0];
        end
        OP_ROLD: begin
            nw = {w[14:0], c};
            nc = w[15];
            nv = w[15] ^ w[14];
        end
        OP_RORD: begin
            nw = {c, w[15:1]};
            nc = w[0];
        end
        default: ;
    endcase
    return {nv, nc, nw};
endfunction

assign a8       = a_q[7:0];
assign b8       = b_q[7:0];
assign cin      = cc_q[CC_C];
assign step_nxt = shift_one(op_q, work_q, work_c, work_v);

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        op_q <= OP_CLR;
    end else if (cen && op_load) begin
        op_q <= op;
    end
end

always_ff @(posedge clk) begin
    if (cen) begin
        if (op_load) begin
            a_q    <= opnd0;
            b_q    <= opnd1;
            cc_q   <= cc_in;
            work_q <= opnd0;            // Shift source is opnd0
            work_c <= cc_in[CC_C];
            work_v <= cc_in[CC_V];
        end else if (shift_step) begin
            {work_v, work_c, work_q} <= step_nxt;
        end
    end
end

always_comb begin
    res     = a_q;                      // 8-bit ops keep the upper byte
    res_hi  = '0;
    cc_new  = cc_q;
    wide    = 1'b0;
    keep_zn = 1'b0;
    sum9    = '0;
    sum17   = '0;
    prod    = '0;
    case (op_q)
        OP_ADD8, OP_ADC8: begin
            sum9 = {1'b0, a8} + {1'b0, b8} + {8'd0, cin && op_q == OP_ADC8};
            res[7:0]     = sum9[7:0];
            cc_new[CC_C] = sum9[8];
            cc_new[CC_V] = a8[7] ^ b8[7] ^ sum9[8] ^ sum9[7];
            cc_new[CC_H] = a8[4] ^ b8[4] ^ sum9[4];
        end
        OP_SUB8, OP_SBC8, OP_CMP8: begin
            sum9 = {1'b0, a8} - {1'b0, b8} - {8'd0, cin && op_q == OP_SBC8};
            res[7:0]     = sum9[7:0];
            cc_new[CC_C] = sum9[8];     // Borrow
            cc_new[CC_V] = a8[7] ^ b8[7] ^ sum9[8] ^ sum9[7];
        end
        OP_ADD16, OP_SUB16, OP_CMP16: begin
            sum17 = op_q == OP_ADD16 ? {1'b0, a_q} + {1'b0, b_q} : {1'b0, a_q} - {1'b0, b_q};
            res          = sum17[15:0];
            cc_new[CC_C] = sum17[16];
            cc_new[CC_V] = a_q[15] ^ b_q[15] ^ sum17[16] ^ sum17[15];
            wide         = 1'b1;
        end
        OP_AND, OP_OR, OP_EOR: begin
            if (op_q == OP_AND) begin
                res[7:0] = a8 & b8;
            end else if (op_q == OP_OR) begin
                res[7:0] = a8 | b8;
            end else begin
                res[7:0] = a8 ^ b8;
            end
            cc_new[CC_V] = 1'b0;
        end
        OP_COM8: begin
            res[7:0]     = ~a8;
            cc_new[CC_C] = 1'b1;
            cc_new[CC_V] = 1'b0;
        end
        OP_NEG8: begin
            sum9 = 9'd0 - {1'b0, a8};
            res[7:0]     = sum9[7:0];
            cc_new[CC_C] = sum9[8];     // Set for any nonzero operand
            cc_new[CC_V] = a8 == 8'h80;
        end
        OP_NEG16: begin
            sum17 = 17'd0 - {1'b0, a_q};
            res          = sum17[15:0];
            cc_new[CC_C] = sum17[16];
            cc_new[CC_V] = a_q == 16'h8000;
            wide         = 1'b1;
        end
        OP_INC8: begin
            res[7:0]     = a8 + 8'd1;
            cc_new[CC_V] = a8 == 8'h7f;
        end
        OP_INC16: begin
            res          = a_q + 16'd1;
            cc_new[CC_V] = a_q == 16'h7fff;
            wide         = 1'b1;
        end
        OP_DEC8: begin
            res[7:0]     = a8 - 8'd1;
            cc_new[CC_V] = a8 == 8'h80;
        end
        OP_DEC16: begin
            res          = a_q - 16'd1;
            cc_new[CC_V] = a_q == 16'h8000;
            wide         = 1'b1;
        end
        OP_CLR: begin
            res          = '0;
            cc_new[CC_C] = 1'b0;
            cc_new[CC_V] = 1'b0;
            wide         = 1'b1;
        end
        OP_LSR8, OP_ASR8: begin
            res[7:0]     = {op_q == OP_ASR8 && a8[7], a8[7:1]};
            cc_new[CC_C] = a8[0];
        end
        OP_ASL8, OP_ROL8: begin
            res[7:0]     = {a8[6:0], op_q == OP_ROL8 && cin};
            cc_new[CC_C] = a8[7];
            cc_new[CC_V] = a8[7] ^ a8[6];
        end
        OP_ROR8: begin
            res[7:0]     = {cin, a8[7:1]};
            cc_new[CC_C] = a8[0];
        end
        OP_SEX: begin
            res          = {{8{a8[7]}}, a8};
            cc_new[CC_V] = 1'b0;
            wide         = 1'b1;
        end
        OP_MUL: begin
            res          = a_q[15:8] * a_q[7:0];
            cc_new[CC_C] = res[7];
            keep_zn      = 1'b1;
        end
        OP_LMUL: begin
            prod         = a_q * b_q;
            res          = prod[15:0];
            res_hi       = prod[31:16];
            cc_new[CC_C] = prod[31];
            keep_zn      = 1'b1;
        end
        OP_ANDCC, OP_ORCC: begin
            cc_new  = op_q == OP_ANDCC ? cc_q & b8 : cc_q | b8;
            keep_zn = 1'b1;
        end
        OP_ASLD, OP_ASRD, OP_LSRD, OP_ROLD, OP_RORD: begin
            res          = work_q;      // Already stepped k times
            cc_new[CC_C] = work_c;
            cc_new[CC_V] = work_v;
            wide         = 1'b1;
        end
        OP_DIVXB: begin
            res          = quot;
            res_hi       = {8'd0, rem};
            cc_new[CC_V] = div_v;
            wide         = 1'b1;
        end
        default: ;
    endcase
    if (!keep_zn) begin
        cc_new[CC_Z] = wide ? res == 16'd0 : res[7:0] == 8'd0;
        cc_new[CC_N] = wide ? res[15] : res[7];
    end
end

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        rslt_q    <= '0;
        rslt_hi_q <= '0;
        cc_out_q  <= '0;
    end else if (cen && capture) begin
        rslt_q    <= res;
        rslt_hi_q <= res_hi;
        cc_out_q  <= cc_new;
    end
end

assign rslt    = capture ? res : rslt_q;      // Held copy after the done cycle
assign rslt_hi = capture ? res_hi : rslt_hi_q;
assign cc_out  = capture ? cc_new : cc_out_q;

endmodule

//--- logic/alu_pkg.sv
/*
 * Execution unit shared definitions
 * Word, byte and condition-code types, the step count type,
 * flag bit positions, the operation encoding and the sequencer states.
 */
package alu_pkg;

    typedef logic [15:0] word_t;        // Operand or result word
    typedef logic [7:0]  byte_t;        // Data byte
    typedef logic [7:0]  cc_t;          // E F H I N Z V C
    typedef logic [4:0]  cnt_t;         // Step count, 0 to 16

    localparam int CC_C = 0;            // Carry
    localparam int CC_V = 1;            // Overflow
    localparam int CC_Z = 2;            // Zero
    localparam int CC_N = 3;            // Negative
    localparam int CC_I = 4;            // IRQ mask
    localparam int CC_H = 5;            // Half carry
    localparam int CC_F = 6;            // FIRQ mask
    localparam int CC_E = 7;            // Entire state saved

    typedef enum logic [5:0] {
        OP_ADD8,
        OP_ADD16,
        OP_ADC8,
        OP_SUB8,
        OP_SUB16,
        OP_SBC8,
        OP_CMP8,
        OP_CMP16,
        OP_AND,
        OP_OR,
        OP_EOR,
        OP_COM8,
        OP_NEG8,
        OP_NEG16,
        OP_INC8,
        OP_INC16,
        OP_DEC8,
        OP_DEC16,
        OP_CLR,
        OP_LSR8,
        OP_ASR8,
        OP_ASL8,
        OP_ROL8,
        OP_ROR8,
        OP_SEX,
        OP_MUL,                         // A*B from opnd0
        OP_LMUL,                        // 16x16 to 32
        OP_ANDCC,
        OP_ORCC,
        OP_ASLD,                        // Multi-bit shifts of opnd0
        OP_ASRD,
        OP_LSRD,
        OP_ROLD,
        OP_RORD,
        OP_DIVXB                        // Unsigned 16 by 8
    } alu_op_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SHIFT,
        ST_DIV,
        ST_DONE
    } seq_state_t;

endpackage

//--- logic/alu_seq.sv
/*
 * Execution sequencer
 * Sorts each started operation into single-cycle, multi-shift or divide,
 * drives the load, step and capture strobes and flags busy and done.
 * The last cycle of a shift or divide is the done cycle itself.
 */
module alu_seq import alu_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    cen,
    input  logic    start,
    input  alu_op_t op,
    input  logic    cnt_zero,
    output logic    busy,
    output logic    done,
    output logic    op_load,
    output logic    cnt_load,
    output logic    cnt_step,
    output logic    shift_step,
    output logic    div_load,
    output logic    div_step,
    output logic    capture
);

seq_state_t state;
seq_state_t nxt;
seq_state_t entry;
logic       is_shift;
logic       is_div;
logic       running;
logic       fin;
logic       accept;

always_comb begin
    is_shift = 1'b0;
    is_div   = 1'b0;
    case (op)
        OP_ASLD, OP_ASRD, OP_LSRD, OP_ROLD, OP_RORD: is_shift = 1'b1;
        OP_DIVXB: is_div = 1'b1;
        default: ;
    endcase
end

assign entry   = is_shift ? ST_SHIFT : (is_div ? ST_DIV : ST_DONE);
assign running = state == ST_SHIFT || state == ST_DIV;
assign fin     = state == ST_DONE || (running && cnt_zero);  // Results valid now
assign accept  = start && (state == ST_IDLE || fin);         // Back to back allowed
assign busy    = running && !cnt_zero;

assign op_load    = accept;
assign cnt_load   = accept && (is_shift || is_div);
assign div_load   = accept && is_div;
assign cnt_step   = busy;
assign shift_step = busy && state == ST_SHIFT;
assign div_step   = busy && state == ST_DIV;
assign capture    = fin && cen;
assign done       = fin && cen;

always_comb begin
    nxt = state;
    if (accept) begin
        nxt = entry;
    end else if (fin) begin
        nxt = ST_IDLE;
    end
end

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        state <= ST_IDLE;
    end else if (cen) begin
        state <= nxt;
    end
end

// A new start in the done cycle may legally retrigger done
a_done_pulse: assert property (@(posedge clk) disable iff (rst)
    done && !start |=> !done);

a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
    cen && busy |-> !start);

endmodule

//--- logic/div_unit.sv
/*
 * Restoring divider
 * Unsigned 16 by 8 division, one quotient bit per step. A zero divisor
 * raises v and leaves quotient FFFF with the dividend low byte as remainder.
 */
module div_unit import alu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  cen,
    input  logic  load,
    input  logic  step,
    input  word_t dividend,
    input  byte_t divisor,
    output word_t quot,
    output byte_t rem,
    output logic  v
);

word_t      dq;                         // Dividend bits out, quotient bits in
byte_t      dvs;
logic [8:0] prem;                       // Partial remainder
logic [8:0] trial;
logic       fits;

assign trial = {prem[7:0], dq[15]};
assign fits  = trial >= {1'b0, dvs};

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        dq   <= '0;
        dvs  <= '0;
        prem <= '0;
    end else if (cen) begin
        if (load) begin
            dq   <= dividend;
            dvs  <= divisor;
            prem <= '0;
        end else if (step) begin
            prem <= fits ? trial - {1'b0, dvs} : trial;  // Restore by keeping trial
            dq   <= {dq[14:0], fits};
        end
    end
end

assign quot = dq;
assign rem  = prem[7:0];
assign v    = dvs == 8'd0;

endmodule

//--- logic/exec_unit.sv
/*
 * Execution unit top level
 * Sequencer, step counter, result core and divider of the
 * 8/16-bit accumulator CPU execution stage.
 */
module exec_unit import alu_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    cen,
    input  logic    start,
    input  alu_op_t op,
    input  word_t   opnd0,
    input  word_t   opnd1,
    input  cc_t     cc_in,
    output logic    busy,
    output logic    done,
    output word_t   rslt,
    output word_t   rslt_hi,
    output cc_t     cc_out
);

logic  cnt_zero;
logic  op_load;
logic  cnt_load;
logic  cnt_step;
logic  shift_step;
logic  div_load;
logic  div_step;
logic  capture;
word_t quot;
byte_t rem;
logic  div_v;

// 16 steps for a divide, opnd1 nibble for a shift
wire cnt_t cnt_init = op == OP_DIVXB ? 5'd16 : {1'b0, opnd1[3:0]};

alu_seq u_seq (
    .clk        ( clk        ),
    .rst        ( rst        ),
    .cen        ( cen        ),
    .start      ( start      ),
    .op         ( op         ),
    .cnt_zero   ( cnt_zero   ),
    .busy       ( busy       ),
    .done       ( done       ),
    .op_load    ( op_load    ),
    .cnt_load   ( cnt_load   ),
    .cnt_step   ( cnt_step   ),
    .shift_step ( shift_step ),
    .div_load   ( div_load   ),
    .div_step   ( div_step   ),
    .capture    ( capture    )
);

step_counter u_cnt (
    .clk      ( clk      ),
    .rst      ( rst      ),
    .cen      ( cen      ),
    .load     ( cnt_load ),
    .step     ( cnt_step ),
    .load_val ( cnt_init ),
    .zero     ( cnt_zero )
);

alu_core u_core (
    .clk        ( clk        ),
    .rst        ( rst        ),
    .cen        ( cen        ),
    .op_load    ( op_load    ),
    .shift_step ( shift_step ),
    .capture    ( capture    ),
    .op         ( op         ),
    .opnd0      ( opnd0      ),
    .opnd1      ( opnd1      ),
    .cc_in      ( cc_in      ),
    .quot       ( quot       ),
    .rem        ( rem        ),
    .div_v      ( div_v      ),
    .rslt       ( rslt       ),
    .rslt_hi    ( rslt_hi    ),
    .cc_out     ( cc_out     )
);

div_unit u_div (
    .clk      ( clk        ),
    .rst      ( rst        ),
    .cen      ( cen        ),
    .load     ( div_load   ),
    .step     ( div_step   ),
    .dividend ( opnd0      ),
    .divisor  ( opnd1[7:0] ),
    .quot     ( quot       ),
    .rem      ( rem        ),
    .v        ( div_v      )
);

endmodule

//--- logic/step_counter.sv
/*
 * Step counter
 * Loadable down-counter timing the shift steps and the divide
 * iterations. zero is high while no steps remain.
 */
module step_counter import alu_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic cen,
    input  logic load,
    input  logic step,
    input  cnt_t load_val,
    output logic zero
);

cnt_t cnt;

assign zero = cnt == '0;

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        cnt <= '0;
    end else if (cen) begin
        if (load) begin
            cnt <= load_val;            // Load wins over step
        end else if (step) begin
            cnt <= cnt - 5'd1;
        end
    end
end

// Underflow would wrap to 31 and hang the sequencer for many cycles
a_no_underflow: assert property (@(posedge clk) disable iff (rst)
    cen && step && !load |-> cnt != '0);

a_in_range: assert property (@(posedge clk) disable iff (rst)
    cen && load |=> cnt <= 5'd16);

endmodule

//--- run_sim.sh
#!/bin/sh
# Build the execution unit testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module exec_unit_tb \
    -f exec_unit.f -o exec_unit_sim &&
./obj_dir/exec_unit_sim > sim.log 2>&1 ||
echo "Build or simulation ended with an error status"

grep -qF '*** TEST PASSED ***' sim.log 2>/dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed, see sim.log"; exit 1; }

//--- sim/exec_unit_tb.sv
/*
 * Execution unit testbench
 * Random single-cycle ops, every multi-shift count and divides, with
 * random clock-enable gaps. A reference model predicts each result and its
 * latency in enabled cycles, and a monitor compares them on done.
 */
module exec_unit_tb import alu_pkg::*; ();

localparam int PERIOD   = 40;
localparam int N_SINGLE = 300;
localparam int N_DIV    = 36;
localparam int N_OPS    = N_SINGLE + 5 * 16 + N_DIV;
localparam int TIMEOUT  = (N_OPS * 20 + 10) * PERIOD;

typedef struct packed {
    alu_op_t    op;
    word_t      r;
    word_t      hi;
    cc_t        cc;
    logic [7:0] lat;                    // Enabled cycles from start to done
} exp_t;

logic        clk;
logic        rst;
logic        cen;
logic        start;
alu_op_t     op;
word_t       opnd0;
word_t       opnd1;
cc_t         cc_in;
logic        busy;
logic        done;
word_t       rslt;
word_t       rslt_hi;
cc_t         cc_out;
logic [31:0] lfsr;
exp_t        exp_q[$];
int          issued;
int          checked;
logic        pending;
int          en_cnt;
int          busy_cnt;
word_t       held_r;
word_t       held_hi;
cc_t         held_cc;

exec_unit dut0 (
    .clk     ( clk     ),
    .rst     ( rst     ),
    .cen     ( cen     ),
    .start   ( start   ),
    .op      ( op      ),
    .opnd0   ( opnd0   ),
    .opnd1   ( opnd1   ),
    .cc_in   ( cc_in   ),
    .busy    ( busy    ),
    .done    ( done    ),
    .rslt    ( rslt    ),
    .rslt_hi ( rslt_hi ),
    .cc_out  ( cc_out  )
);

initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
end

function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
endfunction

// One LFSR step per bit taken
task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
        v    = {v[30:0], lfsr[0]};
        lfsr = lfsr_next(lfsr);
    end
endtask

// Next falling edge, with a fresh random enable
task automatic tick();
    logic [31:0] r;
    @(negedge clk);
    rand_bits(2, r);
    cen = r[1:0] != 2'd0;               // Low about a quarter of the time
endtask

task automatic fail_now(input string msg);
    if (msg != "") begin
        $display("%s", msg);
    end
    $display("*** TEST FAILED ***");
    $fatal(1, "Run stopped at the first error");
endtask

task automatic check_val(input string name, input logic [31:0] expv, input logic [31:0] actv);
    if (expv !== actv) begin
        $display("Error: %s expected %h actual %h", name, expv, actv);
        fail_now("");
    end
endtask

function automatic exp_t ref_exec(alu_op_t o, word_t a, word_t b, cc_t cc);
    exp_t  e;
    int    ua8;
    int    ub8;
    int    ua16;
    int    ub16;
    int    ci;
    int    s;
    byte_t a8;
    byte_t b8;
    byte_t r8;
    word_t w;
    logic  sc;
    logic  sv;
    logic  nb;
    logic  wide;
    logic  set_zn;
    logic [63:0] p;
    a8     = a[7:0];
    b8     = b[7:0];
    ua8    = a8;
    ub8    = b8;
    ua16   = a;
    ub16   = b;
    ci     = cc[CC_C];
    e.op   = o;
    e.r    = a;                         // Upper byte passes through on 8-bit ops
    e.hi   = '0;
    e.cc   = cc;
    e.lat  = 8'd1;
    wide   = 1'b0;
    set_zn = 1'b1;
    case (o)
        OP_ADD8, OP_ADC8: begin
            s  = ua8 + ub8 + (o == OP_ADC8 ? ci : 0);
            r8 = s[7:0];
            e.cc[CC_C] = s > 255;
            e.cc[CC_V] = a8[7] == b8[7] && r8[7] != a8[7];
            e.cc[CC_H] = (ua8 % 16) + (ub8 % 16) + (o == OP_ADC8 ? ci : 0) > 15;
            e.r[7:0]   = r8;
        end
        OP_SUB8, OP_SBC8, OP_CMP8: begin
            s  = ua8 - ub8 - (o == OP_SBC8 ? ci : 0);
            r8 = s[7:0];
            e.cc[CC_C] = s < 0;         // Borrow
            e.cc[CC_V] = a8[7] != b8[7] && r8[7] != a8[7];
            e.r[7:0]   = r8;
        end
        OP_ADD16: begin
            s   = ua16 + ub16;
            e.r = s[15:0];
            e.cc[CC_C] = s > 65535;
            e.cc[CC_V] = a[15] == b[15] && e.r[15] != a[15];
            wide = 1'b1;
        end
        OP_SUB16, OP_CMP16: begin
            s   = ua16 - ub16;
            e.r = s[15:0];
            e.cc[CC_C] = s < 0;
            e.cc[CC_V] = a[15] != b[15] && e.r[15] != a[15];
            wide = 1'b1;
        end
        OP_AND, OP_OR, OP_EOR: begin
            if (o == OP_AND) begin
                e.r[7:0] = a8 & b8;
            end else if (o == OP_OR) begin
                e.r[7:0] = a8 | b8;
            end else begin
                e.r[7:0] = a8 ^ b8;
            end
            e.cc[CC_V] = 1'b0;
        end
        OP_COM8: begin
            e.r[7:0]   = ~a8;
            e.cc[CC_C] = 1'b1;
            e.cc[CC_V] = 1'b0;
        end
        OP_NEG8: begin
            s          = 0 - ua8;
            e.r[7:0]   = s[7:0];
            e.cc[CC_C] = a8 != 8'd0;
            e.cc[CC_V] = a8 == 8'h80;
        end
        OP_NEG16: begin
            s          = 0 - ua16;
            e.r        = s[15:0];
            e.cc[CC_C] = a != 16'd0;
            e.cc[CC_V] = a == 16'h8000;
            wide       = 1'b1;
        end
        OP_INC8: begin
            e.r[7:0]   = a8 + 8'd1;
            e.cc[CC_V] = a8 == 8'h7f;
        end
        OP_INC16: begin
            e.r        = a + 16'd1;
            e.cc[CC_V] = a == 16'h7fff;
            wide       = 1'b1;
        end
        OP_DEC8: begin
            e.r[7:0]   = a8 - 8'd1;
            e.cc[CC_V] = a8 == 8'h80;
        end
        OP_DEC16: begin
            e.r        = a - 16'd1;
            e.cc[CC_V] = a == 16'h8000;
            wide       = 1'b1;
        end
        OP_CLR: begin
            e.r        = '0;
            e.cc[CC_C] = 1'b0;
            e.cc[CC_V] = 1'b0;
            wide       = 1'b1;
        end
        OP_LSR8, OP_ASR8, OP_ROR8: begin
            nb = o == OP_ASR8 ? a8[7] : (o == OP_ROR8 ? cc[CC_C] : 1'b0);
            e.r[7:0]   = {nb, a8[7:1]};
            e.cc[CC_C] = a8[0];
        end
        OP_ASL8, OP_ROL8: begin
            nb = o == OP_ROL8 ? cc[CC_C] : 1'b0;
            e.r[7:0]   = {a8[6:0], nb};
            e.cc[CC_C] = a8[7];
            e.cc[CC_V] = a8[7] ^ a8[6];
        end
        OP_SEX: begin
            e.r        = {{8{a8[7]}}, a8};
            e.cc[CC_V] = 1'b0;
            wide       = 1'b1;
        end
        OP_MUL: begin
            s          = int'(a[15:8]) * ua8;
            e.r        = s[15:0];
            e.cc[CC_C] = e.r[7];
            set_zn     = 1'b0;
        end
        OP_LMUL: begin
            p          = {48'd0, a} * {48'd0, b};
            e.r        = p[15:0];
            e.hi       = p[31:16];
            e.cc[CC_C] = p[31];
            set_zn     = 1'b0;
        end
        OP_ANDCC, OP_ORCC: begin
            e.cc   = o == OP_ANDCC ? cc & b8 : cc | b8;
            set_zn = 1'b0;
        end
        OP_ASLD, OP_ASRD, OP_LSRD, OP_ROLD, OP_RORD: begin
            w  = a;
            sc = cc[CC_C];
            sv = cc[CC_V];                  // Right shifts never touch V
            for (int i = 0; i < int'(b[3:0]); i++) begin
                if (o == OP_ASLD || o == OP_ROLD) begin
                    sv = w[15] ^ w[14];
                    nb = o == OP_ROLD ? sc : 1'b0;
                    sc = w[15];
                    w  = {w[14:0], nb};
                end else begin
                    nb = o == OP_ASRD ? w[15] : (o == OP_RORD ? sc : 1'b0);
                    sc = w[0];
                    w  = {nb, w[15:1]};
                end
            end
            e.r        = w;
            e.cc[CC_C] = sc;
            e.cc[CC_V] = sv;
            e.lat      = 8'(b[3:0]) + 8'd1;
            wide       = 1'b1;
        end
        OP_DIVXB: begin
            e.lat = 8'd17;
            wide  = 1'b1;
            if (b8 == 8'd0) begin
                e.r        = 16'hffff;
                e.hi       = {8'd0, a8};
                e.cc[CC_V] = 1'b1;
            end else begin
                e.r        = 16'(ua16 / ub8);
                e.hi       = 16'(ua16 % ub8);
                e.cc[CC_V] = 1'b0;
            end
        end
        default: ;
    endcase
    if (set_zn) begin
        e.cc[CC_Z] = wide ? e.r == 16'd0 : e.r[7:0] == 8'd0;
        e.cc[CC_N] = wide ? e.r[15] : e.r[7];
    end
    return e;
endfunction

// Hold start until an enabled edge takes it, then wait for the monitor
task automatic run_op(input alu_op_t o, input word_t a, input word_t b, input cc_t c);
    logic [31:0] junk;
    exp_q.push_back(ref_exec(o, a, b, c));
    issued++;
    tick();
    start = 1'b1;
    op    = o;
    opnd0 = a;
    opnd1 = b;
    cc_in = c;
    @(posedge clk);
    while (!cen) begin
        tick();
        @(posedge clk);
    end
    tick();
    start = 1'b0;
    rand_bits(32, junk);                // Operands are free to change now
    opnd0 = junk[15:0];
    opnd1 = junk[31:16];
    rand_bits(14, junk);
    cc_in = junk[7:0];
    op    = alu_op_t'(6'(junk[13:8] % 35));
    while (checked < issued) begin
        tick();
    end
endtask

// Monitor and compare on done
initial begin
    exp_t  e;
    string tn;
    pending  = 1'b0;
    en_cnt   = 0;
    busy_cnt = 0;
    checked  = 0;
    held_r   = '0;
    held_hi  = '0;
    held_cc  = '0;
    forever begin
        @(posedge clk);
        if (!rst) begin
            if (!pending) begin
                check_val("busy while idle", 32'd0, {31'd0, busy});
                if (done) begin
                    fail_now("done pulsed with no operation pending");
                end
                if (start && cen) begin
                    pending  = 1'b1;
                    en_cnt   = 0;
                    busy_cnt = 0;
                end
            end else if (cen) begin
                en_cnt++;
                if (done) begin
                    e  = exp_q.pop_front();
                    tn = $sformatf("%s #%0d", e.op.name(), checked);
                    check_val({tn, " rslt"}, {16'd0, e.r}, {16'd0, rslt});
                    check_val({tn, " rslt_hi"}, {16'd0, e.hi}, {16'd0, rslt_hi});
                    check_val({tn, " cc_out"}, {24'd0, e.cc}, {24'd0, cc_out});
                    check_val({tn, " latency"}, {24'd0, e.lat}, en_cnt);
                    check_val({tn, " busy cycles"}, {24'd0, e.lat} - 1, busy_cnt);
                    check_val({tn, " busy at done"}, 32'd0, {31'd0, busy});
                    held_r  = e.r;
                    held_hi = e.hi;
                    held_cc = e.cc;
                    pending = 1'b0;
                    checked++;
                end else if (busy) begin
                    busy_cnt++;
                end
            end
            if (!done) begin
                check_val("held rslt", {16'd0, held_r}, {16'd0, rslt});
                check_val("held rslt_hi", {16'd0, held_hi}, {16'd0, rslt_hi});
                check_val("held cc_out", {24'd0, held_cc}, {24'd0, cc_out});
            end
        end
    end
end

initial begin
    #(TIMEOUT);
    fail_now("Timeout: the operations did not finish in the allowed time");
end

// Stimulus
initial begin
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    lfsr    = 32'h142d;
    issued  = 0;
    rst     = 1'b1;
    cen     = 1'b1;
    start   = 1'b0;
    op      = OP_CLR;
    opnd0   = '0;
    opnd1   = '0;
    cc_in   = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_val("reset busy", 32'd0, {31'd0, busy});
    check_val("reset done", 32'd0, {31'd0, done});
    check_val("reset rslt", 32'd0, {16'd0, rslt});
    check_val("reset rslt_hi", 32'd0, {16'd0, rslt_hi});
    check_val("reset cc_out", 32'd0, {24'd0, cc_out});

    for (int i = 0; i < N_SINGLE; i++) begin
        rand_bits(5, r0);
        rand_bits(32, r1);
        rand_bits(8, r2);
        run_op(alu_op_t'(6'(r0 % 29)), r1[15:0], r1[31:16], r2[7:0]);
    end

    for (int s = 0; s < 5; s++) begin
        for (int k = 0; k < 16; k++) begin
            rand_bits(32, r1);
            rand_bits(8, r2);
            run_op(alu_op_t'(6'(int'(OP_ASLD) + s)), r1[15:0],
                   {r1[27:16], 4'(k)}, r2[7:0]);
        end
    end

    for (int i = 0; i < N_DIV; i++) begin
        rand_bits(32, r1);
        rand_bits(8, r2);
        if (i % 6 == 0) begin
            r1[23:16] = 8'd0;           // Zero divisor
        end
        run_op(OP_DIVXB, r1[15:0], r1[31:16], r2[7:0]);
    end

    repeat (3) tick();
    if (checked == N_OPS) begin
        $display("*** TEST PASSED ***");
        $finish;
    end else begin
        fail_now("Run ended with missing results");
    end
end

endmodule
